//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary -Wno-fatal
TOP       = zmips_tb
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- logic/zmips.sv
// zmips five-stage core
module zmips
(
    input  logic             clk,
    input  logic             rst,
    output zmips_pkg::word_t i_addr,
    input  zmips_pkg::word_t i_data,
    output zmips_pkg::word_t d_addr,
    output zmips_pkg::word_t d_wdata,
    input  zmips_pkg::word_t d_rdata,
    output logic             d_rd,
    output logic             d_wr
);
    import zmips_pkg::*;

    word_t     if_id_ir;
    logic      stall;
    reg_addr_t rf_addr_0, rf_addr_1;
    word_t     rf_data_0, rf_data_1;

    // ID/EX
    reg_addr_t id_ex_rs, id_ex_rt, id_ex_dest;
    word_t     id_ex_a, id_ex_b, id_ex_imm;
    alu_op_t   id_ex_alu_op;
    logic      id_ex_alusrc, id_ex_mem_rd, id_ex_mem_wr, id_ex_wr_reg;

    // EX/MEM
    word_t     ex_mem_result, ex_mem_store_data;
    reg_addr_t ex_mem_dest;
    logic      ex_mem_mem_rd, ex_mem_mem_wr, ex_mem_wr_reg;

    // Write-back, also forwarded into execute
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      wb_wr;

    zmips_fetch i_fetch
    (
        .clk (clk), .rst (rst), .stall (stall), .i_data (i_data),
        .i_addr (i_addr), .if_id_ir (if_id_ir)
    );

    zmips_regfile i_regfile
    (
        .clk (clk), .rst (rst), .rd_addr_0 (rf_addr_0), .rd_addr_1 (rf_addr_1),
        .wr_addr (wb_addr), .wr_data (wb_data), .wr (wb_wr),
        .rd_data_0 (rf_data_0), .rd_data_1 (rf_data_1)
    );

    zmips_decode i_decode
    (
        .clk (clk), .rst (rst), .if_id_ir (if_id_ir),
        .rf_data_0 (rf_data_0), .rf_data_1 (rf_data_1),
        .rf_addr_0 (rf_addr_0), .rf_addr_1 (rf_addr_1), .stall (stall),
        .id_ex_rs (id_ex_rs), .id_ex_rt (id_ex_rt), .id_ex_dest (id_ex_dest),
        .id_ex_a (id_ex_a), .id_ex_b (id_ex_b), .id_ex_imm (id_ex_imm),
        .id_ex_alu_op (id_ex_alu_op), .id_ex_alusrc (id_ex_alusrc),
        .id_ex_mem_rd (id_ex_mem_rd), .id_ex_mem_wr (id_ex_mem_wr),
        .id_ex_wr_reg (id_ex_wr_reg)
    );

    zmips_execute i_execute
    (
        .clk (clk), .rst (rst),
        .id_ex_rs (id_ex_rs), .id_ex_rt (id_ex_rt), .id_ex_dest (id_ex_dest),
        .id_ex_a (id_ex_a), .id_ex_b (id_ex_b), .id_ex_imm (id_ex_imm),
        .id_ex_alu_op (id_ex_alu_op), .id_ex_alusrc (id_ex_alusrc),
        .id_ex_mem_rd (id_ex_mem_rd), .id_ex_mem_wr (id_ex_mem_wr),
        .id_ex_wr_reg (id_ex_wr_reg),
        .wb_addr (wb_addr), .wb_data (wb_data), .wb_wr (wb_wr),
        .ex_mem_result (ex_mem_result), .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_dest (ex_mem_dest), .ex_mem_mem_rd (ex_mem_mem_rd),
        .ex_mem_mem_wr (ex_mem_mem_wr), .ex_mem_wr_reg (ex_mem_wr_reg)
    );

    zmips_mem_wb i_mem_wb
    (
        .clk (clk), .rst (rst),
        .ex_mem_result (ex_mem_result), .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_dest (ex_mem_dest), .ex_mem_mem_rd (ex_mem_mem_rd),
        .ex_mem_mem_wr (ex_mem_mem_wr), .ex_mem_wr_reg (ex_mem_wr_reg),
        .d_rdata (d_rdata), .d_addr (d_addr), .d_wdata (d_wdata),
        .d_rd (d_rd), .d_wr (d_wr),
        .wb_addr (wb_addr), .wb_data (wb_data), .wb_wr (wb_wr)
    );

endmodule

//--- logic/zmips_alu.sv
// Integer ALU
module zmips_alu
(
    input  zmips_pkg::word_t   a,
    input  zmips_pkg::word_t   b,
    input  zmips_pkg::alu_op_t op,
    output zmips_pkg::word_t   y
);
    import zmips_pkg::*;

    always_comb
    begin
        case (op)
            ALU_AND:
                y = a & b;
            ALU_OR:
                y = a | b;
            ALU_XOR:
                y = a ^ b;
            ALU_ADD:
                y = a + b;                // Wraps, no carry out
            ALU_SUB:
                y = a - b;
            default:
                y = '0;                   // Codes 5 to 7
        endcase
    end

endmodule

//--- logic/zmips_decode.sv
// Decode stage and ID/EX register
module zmips_decode
(
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::word_t     if_id_ir,
    input  zmips_pkg::word_t     rf_data_0,
    input  zmips_pkg::word_t     rf_data_1,
    output zmips_pkg::reg_addr_t rf_addr_0,
    output zmips_pkg::reg_addr_t rf_addr_1,
    output logic                 stall,
    output zmips_pkg::reg_addr_t id_ex_rs,
    output zmips_pkg::reg_addr_t id_ex_rt,
    output zmips_pkg::reg_addr_t id_ex_dest,
    output zmips_pkg::word_t     id_ex_a,
    output zmips_pkg::word_t     id_ex_b,
    output zmips_pkg::word_t     id_ex_imm,
    output zmips_pkg::alu_op_t   id_ex_alu_op,
    output logic                 id_ex_alusrc,
    output logic                 id_ex_mem_rd,
    output logic                 id_ex_mem_wr,
    output logic                 id_ex_wr_reg
);
    import zmips_pkg::*;

    opcode_t   opcode;
    reg_addr_t rs, rt, rd;
    logic [5:0] funct;
    word_t     imm_se;

    // Decoded control before the ID/EX register
    reg_addr_t dec_dest;
    alu_op_t   dec_alu_op;
    logic      dec_alusrc, dec_mem_rd, dec_mem_wr, dec_wr_reg;

    // Field split
    assign opcode = opcode_t'(if_id_ir[31:26]);
    assign rs     = if_id_ir[25:21];
    assign rt     = if_id_ir[20:16];
    assign rd     = if_id_ir[15:11];
    assign funct  = if_id_ir[5:0];
    assign imm_se = {{16{if_id_ir[15]}}, if_id_ir[15:0]};

    assign rf_addr_0 = rs;
    assign rf_addr_1 = rt;

    always_comb
    begin
        dec_dest   = rt;                  // I-format writes rt
        dec_alu_op = ALU_ADD;             // Address add for LW and SW
        dec_alusrc = 1'b0;
        dec_mem_rd = 1'b0;
        dec_mem_wr = 1'b0;
        dec_wr_reg = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                dec_dest   = rd;
                dec_alu_op = alu_op_t'(funct[5:3]);
                dec_wr_reg = 1'b1;
            end
            OP_ADDI:
            begin
                dec_alusrc = 1'b1;
                dec_wr_reg = 1'b1;
            end
            OP_SUBI:
            begin
                dec_alu_op = ALU_SUB;
                dec_alusrc = 1'b1;
                dec_wr_reg = 1'b1;
            end
            OP_LW:
            begin
                dec_alusrc = 1'b1;
                dec_mem_rd = 1'b1;
                dec_wr_reg = 1'b1;
            end
            OP_SW:
            begin
                dec_alusrc = 1'b1;
                dec_mem_wr = 1'b1;
            end
            default: ;                    // Unknown opcode acts as a no-op
        endcase
    end

    // Load in execute whose target is read here
    assign stall = id_ex_mem_rd && (id_ex_rt == rs || id_ex_rt == rt);

    // ID/EX control, bubble on stall
    always_ff @(posedge clk)
    begin
        if (rst || stall)
        begin
            id_ex_alu_op <= ALU_AND;
            id_ex_alusrc <= 1'b0;
            id_ex_mem_rd <= 1'b0;
            id_ex_mem_wr <= 1'b0;
            id_ex_wr_reg <= 1'b0;
        end
        else
        begin
            id_ex_alu_op <= dec_alu_op;
            id_ex_alusrc <= dec_alusrc;
            id_ex_mem_rd <= dec_mem_rd;
            id_ex_mem_wr <= dec_mem_wr;
            id_ex_wr_reg <= dec_wr_reg;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        id_ex_rs   <= rs;
        id_ex_rt   <= rt;
        id_ex_dest <= dec_dest;
        id_ex_a    <= rf_data_0;
        id_ex_b    <= rf_data_1;
        id_ex_imm  <= imm_se;
    end

endmodule

//--- logic/zmips_execute.sv
// Execute stage and EX/MEM register
module zmips_execute
(
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::reg_addr_t id_ex_rs,
    input  zmips_pkg::reg_addr_t id_ex_rt,
    input  zmips_pkg::reg_addr_t id_ex_dest,
    input  zmips_pkg::word_t     id_ex_a,
    input  zmips_pkg::word_t     id_ex_b,
    input  zmips_pkg::word_t     id_ex_imm,
    input  zmips_pkg::alu_op_t   id_ex_alu_op,
    input  logic                 id_ex_alusrc,
    input  logic                 id_ex_mem_rd,
    input  logic                 id_ex_mem_wr,
    input  logic                 id_ex_wr_reg,
    input  zmips_pkg::reg_addr_t wb_addr,
    input  zmips_pkg::word_t     wb_data,
    input  logic                 wb_wr,
    output zmips_pkg::word_t     ex_mem_result,
    output zmips_pkg::word_t     ex_mem_store_data,
    output zmips_pkg::reg_addr_t ex_mem_dest,
    output logic                 ex_mem_mem_rd,
    output logic                 ex_mem_mem_wr,
    output logic                 ex_mem_wr_reg
);
    import zmips_pkg::*;

    fwd_sel_t sel_a, sel_b;
    word_t    fwd_a, fwd_b;
    word_t    alu_b, alu_y;

    // Newest producer wins
    function automatic fwd_sel_t fwd_pick(reg_addr_t src, logic mem_wr_reg, reg_addr_t mem_dest,
                                          logic wb_wr_reg, reg_addr_t wb_dest);
        if (mem_wr_reg && mem_dest == src)
            return FWD_MEM;
        else if (wb_wr_reg && wb_dest == src)
            return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t wb_val,
                                      word_t mem_val);
        case (sel)
            FWD_WB:  return wb_val;
            FWD_MEM: return mem_val;
            default: return reg_val;
        endcase
    endfunction

    assign sel_a = fwd_pick(id_ex_rs, ex_mem_wr_reg, ex_mem_dest, wb_wr, wb_addr);
    assign sel_b = fwd_pick(id_ex_rt, ex_mem_wr_reg, ex_mem_dest, wb_wr, wb_addr);
    assign fwd_a = fwd_mux(sel_a, id_ex_a, wb_data, ex_mem_result);
    assign fwd_b = fwd_mux(sel_b, id_ex_b, wb_data, ex_mem_result);

    assign alu_b = id_ex_alusrc ? id_ex_imm : fwd_b;  // Immediate for I-format

    zmips_alu i_alu
    (
        .a  (fwd_a),
        .b  (alu_b),
        .op (id_ex_alu_op),
        .y  (alu_y)
    );

    // EX/MEM control
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex_mem_mem_rd <= 1'b0;
            ex_mem_mem_wr <= 1'b0;
            ex_mem_wr_reg <= 1'b0;
        end
        else
        begin
            ex_mem_mem_rd <= id_ex_mem_rd;
            ex_mem_mem_wr <= id_ex_mem_wr;
            ex_mem_wr_reg <= id_ex_wr_reg;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk)
    begin
        ex_mem_result     <= alu_y;       // Also the memory address
        ex_mem_store_data <= fwd_b;       // Forwarded rt for SW
        ex_mem_dest       <= id_ex_dest;
    end

endmodule

//--- logic/zmips_fetch.sv
// Fetch stage
module zmips_fetch
(
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,    // Load-use hold from decode
    input  zmips_pkg::word_t i_data,
    output zmips_pkg::word_t i_addr,
    output zmips_pkg::word_t if_id_ir
);
    import zmips_pkg::*;

    word_t pc;

    // Program counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else if (!stall)
        begin
            pc <= pc + INSTR_STEP;        // Straight-line only, no branches
        end
    end

    assign i_addr = pc;                   // ROM answers in the same cycle

    // IF/ID instruction register
    always_ff @(posedge clk)
    begin
        if (rst)
            if_id_ir <= NOP_WORD;
        else if (!stall)
            if_id_ir <= i_data;           // Held so the stalled instruction decodes again
    end

endmodule

//--- logic/zmips_mem_wb.sv
// Memory access and write-back
module zmips_mem_wb
(
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::word_t     ex_mem_result,
    input  zmips_pkg::word_t     ex_mem_store_data,
    input  zmips_pkg::reg_addr_t ex_mem_dest,
    input  logic                 ex_mem_mem_rd,
    input  logic                 ex_mem_mem_wr,
    input  logic                 ex_mem_wr_reg,
    input  zmips_pkg::word_t     d_rdata,
    output zmips_pkg::word_t     d_addr,
    output zmips_pkg::word_t     d_wdata,
    output logic                 d_rd,
    output logic                 d_wr,
    output zmips_pkg::reg_addr_t wb_addr,
    output zmips_pkg::word_t     wb_data,
    output logic                 wb_wr
);
    import zmips_pkg::*;

    word_t mem_wb_mem_data;               // Loaded word
    word_t mem_wb_alu_data;               // ALU result
    logic  mem_wb_mem_rd;

    // Data memory sees the EX/MEM entry for one cycle
    assign d_addr  = ex_mem_result;
    assign d_wdata = ex_mem_store_data;
    assign d_rd    = ex_mem_mem_rd;
    assign d_wr    = ex_mem_mem_wr;

    // MEM/WB control
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_wb_mem_rd <= 1'b0;
            wb_wr         <= 1'b0;
        end
        else
        begin
            mem_wb_mem_rd <= ex_mem_mem_rd;
            wb_wr         <= ex_mem_wr_reg;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk)
    begin
        mem_wb_mem_data <= d_rdata;
        mem_wb_alu_data <= ex_mem_result;
        wb_addr         <= ex_mem_dest;
    end

    assign wb_data = mem_wb_mem_rd ? mem_wb_mem_data : mem_wb_alu_data;  // Loads take RAM data

endmodule

//--- logic/zmips_pkg.sv
// zmips shared definitions
package zmips_pkg;

    typedef logic [31:0] word_t;          // Data and address word
    typedef logic [4:0]  reg_addr_t;      // Register number

    localparam int NUM_REGS = 32;

    // Primary opcode, instruction bits 31 to 26
    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'h00,                 // Operation taken from funct
        OP_SUBI  = 6'h10,                 // rt = rs - se_imm
        OP_ADDI  = 6'h11,                 // rt = rs + se_imm
        OP_LW    = 6'h16,                 // rt = mem[rs + se_imm]
        OP_SW    = 6'h17                  // mem[rs + se_imm] = rt
    } opcode_t;

    // ALU operation, funct bits 5 to 3 for R-format
    typedef enum logic [2:0]
    {
        ALU_AND = 3'd0,
        ALU_OR  = 3'd1,
        ALU_XOR = 3'd2,
        ALU_ADD = 3'd3,
        ALU_SUB = 3'd4
    } alu_op_t;

    // Operand source in execute
    typedef enum logic [1:0]
    {
        FWD_REG,                          // Value read in decode
        FWD_WB,                           // MEM/WB write-back data
        FWD_MEM                           // EX/MEM ALU result
    } fwd_sel_t;

    localparam word_t NOP_WORD   = 32'h0000_0000;  // AND r0, r0, r0
    localparam word_t INSTR_STEP = 32'd4;           // PC increment

endpackage

//--- logic/zmips_regfile.sv
// Register file
module zmips_regfile
(
    input  logic                clk,
    input  logic                rst,
    input  zmips_pkg::reg_addr_t rd_addr_0,
    input  zmips_pkg::reg_addr_t rd_addr_1,
    input  zmips_pkg::reg_addr_t wr_addr,
    input  zmips_pkg::word_t    wr_data,
    input  logic                wr,
    output zmips_pkg::word_t    rd_data_0,
    output zmips_pkg::word_t    rd_data_1
);
    import zmips_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;            // All registers start at zero
        end
        else if (wr)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so decode sees the value being written back
    assign rd_data_0 = (wr && wr_addr == rd_addr_0) ? wr_data : regs[rd_addr_0];
    assign rd_data_1 = (wr && wr_addr == rd_addr_1) ? wr_data : regs[rd_addr_1];

endmodule

//--- tb/zmips_tb_prog.svh
// Test program and data RAM size
`ifndef ZMIPS_TB_PROG_SVH
`define ZMIPS_TB_PROG_SVH

localparam int RAM_WORDS = 64;            // Byte addresses 0 to 0xfc
localparam int PROG_LEN  = 36;

// Stores go to 0x80 and up
localparam word_t PROG [PROG_LEN] = '{
    32'h5801_0000,                        // lw   r1, 0x00(r0)
    32'h5802_0004,                        // lw   r2, 0x04(r0)
    32'h0022_1800,                        // and  r3, r1, r2    load-use on r2
    32'h5C03_0080,                        // sw   r3, 0x80(r0)
    32'h0022_2008,                        // or   r4, r1, r2
    32'h0081_2810,                        // xor  r5, r4, r1    distance one
    32'h5C04_0084,                        // sw   r4, 0x84(r0)  distance two
    32'h5C05_0088,                        // sw   r5, 0x88(r0)
    32'h0022_3018,                        // add  r6, r1, r2
    32'h00C1_3820,                        // sub  r7, r6, r1
    32'h5C06_008C,                        // sw   r6, 0x8c(r0)
    32'h5C07_0090,                        // sw   r7, 0x90(r0)
    32'h4428_1234,                        // addi r8, r1, 0x1234
    32'h0102_A028,                        // ALU code 5 on r8 and r2 into r20 gives zero
    32'h5C08_0094,                        // sw   r8, 0x94(r0)
    32'h4049_0055,                        // subi r9, r2, 0x55
    32'h5C09_0098,                        // sw   r9, 0x98(r0)
    32'h442A_FF80,                        // addi r10, r1, -128
    32'h414B_FFF0,                        // subi r11, r10, -16
    32'h5C0A_009C,                        // sw   r10, 0x9c(r0)
    32'h5C0B_00A0,                        // sw   r11, 0xa0(r0)
    32'h580C_0008,                        // lw   r12, 0x08(r0)
    32'h5C0C_00A4,                        // sw   r12, 0xa4(r0) load-use on store data
    32'h580D_0080,                        // lw   r13, 0x80(r0) reads back a store
    32'h45AE_0001,                        // addi r14, r13, 1   load-use on rs
    32'h01CD_7820,                        // sub  r15, r14, r13
    32'h5C0F_00A8,                        // sw   r15, 0xa8(r0)
    32'h5C0E_00AC,                        // sw   r14, 0xac(r0)
    32'h4410_00C0,                        // addi r16, r0, 0xc0
    32'h5E01_0004,                        // sw   r1, 4(r16)    forwarded base
    32'h5A11_FFFC,                        // lw   r17, -4(r16)
    32'h0022_9018,                        // add  r18, r1, r2
    32'h0232_9820,                        // sub  r19, r17, r18 load at distance two
    32'h5C13_00B0,                        // sw   r19, 0xb0(r0)
    32'h5C12_00B4,                        // sw   r18, 0xb4(r0) register file write-through
    32'h5C14_00B8                         // sw   r20, 0xb8(r0)
};

`endif

//--- tb/zmips_tb.sv
// zmips pipeline testbench
module zmips_tb;
    import zmips_pkg::*;

`include "zmips_tb_prog.svh"

    localparam logic [31:0] LCG_SEED    = 32'h2c9ebcba;
    localparam int          CYCLE_LIMIT = 2 * PROG_LEN + 16;
    localparam word_t       ROM_BYTES   = 4 * PROG_LEN;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    word_t i_addr;
    word_t i_data;
    word_t d_addr;
    word_t d_wdata;
    word_t d_rdata;
    logic  d_rd;
    logic  d_wr;

    word_t rom [PROG_LEN];
    word_t ram [RAM_WORDS];

    // Expected traffic from the architectural model
    word_t exp_st_addr [$];
    word_t exp_st_data [$];
    word_t exp_ld_addr [$];
    word_t exp_fetch [$];

    int st_seen;
    int ld_seen;
    int fetch_seen;
    int cycles;

    always #5 clk = ~clk;

    zmips i_zmips
    (
        .clk (clk), .rst (rst), .i_addr (i_addr), .i_data (i_data),
        .d_addr (d_addr), .d_wdata (d_wdata), .d_rdata (d_rdata),
        .d_rd (d_rd), .d_wr (d_wr)
    );

    // Instruction ROM with NOP past the program
    assign i_data = ($isunknown(i_addr) || i_addr >= ROM_BYTES) ? NOP_WORD : rom[i_addr[7:2]];

    // Data RAM with combinational read and rising-edge write
    assign d_rdata = $isunknown(d_addr) ? '0 : ram[d_addr[7:2]];

    always @(posedge clk)
    begin
        if (d_wr)
            ram[d_addr[7:2]] <= d_wdata;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(word_t got, word_t exp, string what);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t: %s is 0x%h, expected 0x%h",
                                $time, what, got, exp));
    endtask

    task automatic check_strobe(logic got, logic exp, string what);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic load_rom();
        for (int k = 0; k < PROG_LEN; k++)
            rom[k] = PROG[k];
    endtask

    task automatic fill_ram();
        logic [31:0] state;
        state = LCG_SEED;
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            state = lcg_next(state ^ word_t'(i * 4));  // Byte address mixed into each word
            ram[i] = state;
        end
    endtask

    // In-order model from zero registers and the initial RAM
    task automatic run_model();
        word_t     regs [NUM_REGS];
        word_t     mram [RAM_WORDS];
        word_t     ir;
        word_t     prev;
        word_t     a;
        word_t     b;
        word_t     se;
        word_t     ea;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic      hold;
        for (int i = 0; i < NUM_REGS; i++)
            regs[i] = '0;
        for (int i = 0; i < RAM_WORDS; i++)
            mram[i] = ram[i];
        prev = NOP_WORD;                  // Reset leaves a bubble ahead of the first one
        exp_fetch.push_back('0);
        for (int k = 0; k < PROG_LEN; k++)
        begin
            ir = rom[k];
            rs = ir[25:21];
            rt = ir[20:16];
            rd = ir[15:11];
            se = {{16{ir[15]}}, ir[15:0]};
            a  = regs[rs];
            b  = regs[rt];
            ea = a + se;
            // Load just ahead with its rt read here holds fetch once
            hold = (prev[31:26] == OP_LW) && (prev[20:16] == rs || prev[20:16] == rt);
            exp_fetch.push_back(INSTR_STEP * (k + 1));
            if (hold)
                exp_fetch.push_back(INSTR_STEP * (k + 1));
            case (opcode_t'(ir[31:26]))
                OP_RTYPE:
                begin
                    case (ir[5:3])
                        3'd0:    regs[rd] = a & b;
                        3'd1:    regs[rd] = a | b;
                        3'd2:    regs[rd] = a ^ b;
                        3'd3:    regs[rd] = a + b;
                        3'd4:    regs[rd] = a - b;
                        default: regs[rd] = '0;   // Codes 5 to 7
                    endcase
                end
                OP_ADDI: regs[rt] = a + se;
                OP_SUBI: regs[rt] = a - se;
                OP_LW:
                begin
                    exp_ld_addr.push_back(ea);
                    regs[rt] = mram[ea[7:2]];
                end
                OP_SW:
                begin
                    exp_st_addr.push_back(ea);
                    exp_st_data.push_back(b);
                    mram[ea[7:2]] = b;
                end
                default: ;                // No architectural effect
            endcase
            prev = ir;
        end
    endtask

    initial
    begin
        load_rom();
        fill_ram();
        run_model();

        // Strobes quiet and PC at zero through the eight reset cycles
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            check_strobe(d_rd, 1'b0, "d_rd in reset");
            check_strobe(d_wr, 1'b0, "d_wr in reset");
            check_addr(i_addr, '0, "i_addr in reset");
        end
        rst        = 1'b0;
        cycles     = 0;
        st_seen    = 0;
        ld_seen    = 0;
        fetch_seen = 0;

        while (st_seen < exp_st_addr.size() || ld_seen < exp_ld_addr.size() ||
               fetch_seen < exp_fetch.size())
        begin
            if (cycles == 1)
            begin
                check_strobe(d_rd, 1'b0, "d_rd after reset");  // First cycle out of reset
                check_strobe(d_wr, 1'b0, "d_wr after reset");
            end
            if (fetch_seen < exp_fetch.size())
            begin
                check_addr(i_addr, exp_fetch[fetch_seen], $sformatf("fetch %0d", fetch_seen));
                fetch_seen++;
            end
            if (d_rd === 1'b1)
            begin
                if (ld_seen >= exp_ld_addr.size())
                    abort_run($sformatf("Load from 0x%h after all %0d expected loads",
                                        d_addr, exp_ld_addr.size()));
                else
                begin
                    check_addr(d_addr, exp_ld_addr[ld_seen],
                               $sformatf("load %0d address", ld_seen));
                    ld_seen++;
                end
            end
            if (d_wr === 1'b1)
            begin
                if (st_seen >= exp_st_addr.size())
                    abort_run($sformatf("Store to 0x%h after all %0d expected stores",
                                        d_addr, exp_st_addr.size()));
                else
                begin
                    check_addr(d_addr, exp_st_addr[st_seen],
                               $sformatf("store %0d address", st_seen));
                    check_word(d_wdata, exp_st_data[st_seen],
                               $sformatf("store %0d data", st_seen));
                    st_seen++;
                end
            end
            cycles++;
            if (cycles > CYCLE_LIMIT)
                abort_run($sformatf("Timed out after %0d cycles with %0d of %0d stores seen",
                                    cycles, st_seen, exp_st_addr.size()));
            @(negedge clk);
        end

        // Only NOPs remain so no further memory traffic
        repeat (4)
        begin
            check_strobe(d_rd, 1'b0, "d_rd after the last load");
            check_strobe(d_wr, 1'b0, "d_wr after the last store");
            @(negedge clk);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+tb
logic/zmips_pkg.sv
logic/zmips_regfile.sv
logic/zmips_fetch.sv
logic/zmips_decode.sv
logic/zmips_alu.sv
logic/zmips_execute.sv
logic/zmips_mem_wb.sv
logic/zmips.sv
tb/zmips_tb.sv
